// ==== common/logPkg.sv ====
// logger package with the fixed card layout, vector types and controller states
`default_nettype none

package logPkg;

  // ------------------------------------------------------------------
  // vector types
  // ------------------------------------------------------------------
  // one data byte
  typedef logic [7:0] byteT;
  // absolute sector number on the card
  typedef logic [31:0] sectorAddrT;
  // byte position inside a 512-byte sector
  typedef logic [8:0] byteIdxT;
  // fifo fill level from 0 up to and including the depth
  typedef logic [10:0] fifoCountT;
  // file length in bytes as stored in the entry
  typedef logic [31:0] fileLenT;

  // ------------------------------------------------------------------
  // sizes and timing
  // ------------------------------------------------------------------
  // clk cycles per serial bit
  localparam int clksPerBit = 16;
  localparam int sectorBytes = 512;
  localparam int fifoDepth = 1024;

  // ------------------------------------------------------------------
  // fixed card layout in place of the mbr and boot sector reads
  // ------------------------------------------------------------------
  // cluster 3 at 64 sectors per cluster
  localparam sectorAddrT dataStartSector = 32'h0000_2040;
  // root directory in cluster 2
  localparam sectorAddrT dirSector = 32'h0000_2000;
  localparam logic [31:0] firstCluster = 32'h0000_0003;
  // 8.3 short name blank padded with the first character in the top byte
  localparam logic [87:0] fileName83 = "LOG     DAT";
  localparam logic [7:0] archiveAttr = 8'h20;

  // controller states for a data sector and then the directory sector
  typedef enum logic [2:0] {
    waitData,
    dataStart,
    dataStream,
    dataWait,
    dirStart,
    dirStream,
    dirWait
  } writerStateT;

endpackage

`default_nettype wire

// ==== design/uart/uartRx.sv ====
// uart receiver, 8N1 with input synchroniser, mid-bit sampling and framing check
`timescale 1ns/1ps
`default_nettype none

module uartRx import logPkg::*; (
  input  wire  clk,
  input  wire  rstn,
  input  wire  rx,
  output byteT rxByte,
  output logic rxValid
);

  typedef enum logic [1:0] {
    rxIdle,
    rxStart,
    rxData,
    rxStop
  } rxStateT;

  rxStateT state;
  logic rxMeta;
  logic rxSync;
  logic rxPrev;
  logic [$clog2(clksPerBit)-1:0] bitTimer;
  logic [2:0] bitNum;
  byteT shiftReg;

  // ------------------------------------------------------------------
  // two-flop synchroniser plus one delayed copy for the edge
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
      rxPrev <= 1'b1;
    end else begin
      rxMeta <= rx;
      rxSync <= rxMeta;
      rxPrev <= rxSync;
    end
  end

  // ------------------------------------------------------------------
  // frame FSM
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= rxIdle;
      bitTimer <= '0;
      bitNum <= '0;
      rxValid <= 1'b0;
    end else begin
      // strobe, one cycle only
      rxValid <= 1'b0;
      bitTimer <= bitTimer + 1'b1;
      case (state)
        rxIdle: begin
          bitTimer <= '0;
          // falling edge marks a start bit
          if (rxPrev && !rxSync) begin
            state <= rxStart;
          end
        end
        rxStart: begin
          // half a bit in: still low or it was a glitch
          if (int'(bitTimer) == clksPerBit / 2 - 1) begin
            bitTimer <= '0;
            bitNum <= '0;
            state <= rxSync ? rxIdle : rxData;
          end
        end
        rxData: begin
          if (int'(bitTimer) == clksPerBit - 1) begin
            bitTimer <= '0;
            bitNum <= bitNum + 1'b1;
            if (bitNum == 3'd7) begin
              state <= rxStop;
            end
          end
        end
        rxStop: begin
          // good frame only when stop bit is high
          if (int'(bitTimer) == clksPerBit - 1) begin
            rxValid <= rxSync;
            state <= rxIdle;
          end
        end
        default: state <= rxIdle;
      endcase
    end
  end

  // data bits, lsb first, shifted in at mid-bit
  always_ff @(posedge clk) begin
    if (state == rxData && int'(bitTimer) == clksPerBit - 1) begin
      shiftReg <= {rxSync, shiftReg[7:1]};
    end
  end

  assign rxByte = shiftReg;

  // one push per frame into the fifo
  assert property (@(posedge clk) disable iff (!rstn) rxValid |=> !rxValid);

endmodule

`default_nettype wire

// ==== design/byteFifo.sv ====
// byte FIFO, first-word-fall-through circular buffer with fill count
`timescale 1ns/1ps
`default_nettype none

module byteFifo import logPkg::*; (
  input  wire       clk,
  input  wire       rstn,
  input  wire       push,
  input  byteT      pushByte,
  input  wire       pop,
  output byteT      headByte,
  output fifoCountT fillCount
);

  byteT mem [fifoDepth];
  logic [$clog2(fifoDepth)-1:0] wrPtr;
  logic [$clog2(fifoDepth)-1:0] rdPtr;
  logic pushOk;
  logic popOk;

  // full drops the incoming byte
  assign pushOk = push && (int'(fillCount) < fifoDepth);
  assign popOk = pop && (fillCount != '0);

  // ------------------------------------------------------------------
  // pointers and level
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wrPtr <= '0;
      rdPtr <= '0;
      fillCount <= '0;
    end else begin
      // depth is a power of two, pointers wrap by themselves
      if (pushOk) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (popOk) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({pushOk, popOk})
        2'b10: fillCount <= fillCount + 1'b1;
        2'b01: fillCount <= fillCount - 1'b1;
        default: fillCount <= fillCount;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (pushOk) begin
      mem[wrPtr] <= pushByte;
    end
  end

  // oldest entry, no read latency
  assign headByte = mem[rdPtr];

  // controller side must never pop an empty buffer
  assert property (@(posedge clk) disable iff (!rstn) pop |-> fillCount != '0);

endmodule

`default_nettype wire

// ==== design/logWriter/dirEntryBuilder.sv ====
// directory sector generator, one byte per index from the 8.3 entry fields
`timescale 1ns/1ps
`default_nettype none

module dirEntryBuilder import logPkg::*; (
  input  byteIdxT entryIdx,
  input  fileLenT fileLen,
  output byteT    entryByte
);

  // ------------------------------------------------------------------
  // entry 0 of the sector, everything else zero
  // ------------------------------------------------------------------
  always_comb begin
    entryByte = 8'h00;
    if (entryIdx <= 9'd10) begin
      // name, first character first
      entryByte = fileName83[87 - 8 * int'(entryIdx) -: 8];
    end else begin
      case (entryIdx)
        // attribute
        9'd11: entryByte = archiveAttr;
        // start cluster high half
        9'd20: entryByte = firstCluster[23:16];
        9'd21: entryByte = firstCluster[31:24];
        // start cluster low half
        9'd26: entryByte = firstCluster[7:0];
        9'd27: entryByte = firstCluster[15:8];
        // file size, little-endian
        9'd28: entryByte = fileLen[7:0];
        9'd29: entryByte = fileLen[15:8];
        9'd30: entryByte = fileLen[23:16];
        9'd31: entryByte = fileLen[31:24];
        // reserved, times and dates left zero
        default: entryByte = 8'h00;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/logWriter/logWriter.sv ====
// log controller, writes each full sector from the FIFO and then rewrites the directory
`timescale 1ns/1ps
`default_nettype none

module logWriter import logPkg::*; (
  input  wire        clk,
  input  wire        rstn,
  input  fifoCountT  fillCount,
  input  byteT       headByte,
  output logic       pop,
  output logic       sectorStart,
  output sectorAddrT sectorAddr,
  output logic       wrValid,
  output byteT       wrByte,
  input  wire        wrReady,
  input  wire        sectorDone
);

  writerStateT state;
  byteIdxT byteIdx;
  // data sectors written so far
  logic [22:0] sectorCount;
  fileLenT fileLen;
  byteT entryByte;
  logic dataPhase;
  logic xfer;
  logic lastByte;
  logic sectorReady;

  // ------------------------------------------------------------------
  // directory bytes
  // ------------------------------------------------------------------
  dirEntryBuilder dirEntryBuilder_i (
    .entryIdx  (byteIdx),
    .fileLen   (fileLen),
    .entryByte (entryByte)
  );

  // ------------------------------------------------------------------
  // block device side, decoded from state
  // ------------------------------------------------------------------
  assign dataPhase = (state == dataStart) || (state == dataStream) || (state == dataWait);
  assign sectorStart = (state == dataStart) || (state == dirStart);
  // next data sector, or the fixed directory sector
  assign sectorAddr = dataPhase ? dataStartSector + sectorAddrT'(sectorCount) : dirSector;
  assign wrValid = (state == dataStream) || (state == dirStream);
  // fifo head holds still until popped
  assign wrByte = dataPhase ? headByte : entryByte;

  // accepted transfer
  assign xfer = wrValid && wrReady;
  // every data byte taken leaves the fifo
  assign pop = xfer && (state == dataStream);
  assign lastByte = (byteIdx == byteIdxT'(sectorBytes - 1));
  assign sectorReady = (int'(fillCount) >= sectorBytes);

  // whole sectors only, so the low bits stay zero
  assign fileLen = {sectorCount, 9'd0};

  // ------------------------------------------------------------------
  // controller FSM
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= waitData;
      byteIdx <= '0;
      sectorCount <= '0;
    end else begin
      // index wraps to 0 after byte 511
      if (xfer) begin
        byteIdx <= byteIdx + 1'b1;
      end
      case (state)
        waitData: begin
          if (sectorReady) begin
            state <= dataStart;
          end
        end
        dataStart: state <= dataStream;
        dataStream: begin
          if (xfer && lastByte) begin
            state <= dataWait;
          end
        end
        dataWait: begin
          // count first, so the entry below already holds this sector
          if (sectorDone) begin
            sectorCount <= sectorCount + 1'b1;
            state <= dirStart;
          end
        end
        dirStart: state <= dirStream;
        dirStream: begin
          if (xfer && lastByte) begin
            state <= dirWait;
          end
        end
        dirWait: begin
          // straight into the next sector when one is waiting
          if (sectorDone) begin
            state <= sectorReady ? dataStart : waitData;
          end
        end
        default: state <= waitData;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // handshake checks
  // ------------------------------------------------------------------
  assert property (@(posedge clk) disable iff (!rstn) sectorStart |=> !sectorStart);

  // back-pressure holds the offered byte, from fifo head or builder
  assert property (@(posedge clk) disable iff (!rstn)
    (wrValid && !wrReady) |=> (wrValid && $stable(wrByte)));

endmodule

`default_nettype wire

// ==== design/fileLogger.sv ====
// uart-to-file logger top, receiver into FIFO into the sector write controller
`timescale 1ns/1ps
`default_nettype none

module fileLogger import logPkg::*; (
  input  wire        clk,
  input  wire        rstn,
  input  wire        rx,
  output logic       sectorStart,
  output sectorAddrT sectorAddr,
  output logic       wrValid,
  output byteT       wrByte,
  input  wire        wrReady,
  input  wire        sectorDone
);

  // receiver to fifo
  byteT rxByte;
  logic rxValid;
  // fifo to controller
  byteT headByte;
  fifoCountT fillCount;
  logic pop;

  // ------------------------------------------------------------------
  // serial input
  // ------------------------------------------------------------------
  uartRx uartRx_i (
    .clk     (clk),
    .rstn    (rstn),
    .rx      (rx),
    .rxByte  (rxByte),
    .rxValid (rxValid)
  );

  // ------------------------------------------------------------------
  // sector buffer, two sectors deep
  // ------------------------------------------------------------------
  byteFifo byteFifo_i (
    .clk       (clk),
    .rstn      (rstn),
    .push      (rxValid),
    .pushByte  (rxByte),
    .pop       (pop),
    .headByte  (headByte),
    .fillCount (fillCount)
  );

  // ------------------------------------------------------------------
  // data and directory sector writes
  // ------------------------------------------------------------------
  logWriter logWriter_i (
    .clk         (clk),
    .rstn        (rstn),
    .fillCount   (fillCount),
    .headByte    (headByte),
    .pop         (pop),
    .sectorStart (sectorStart),
    .sectorAddr  (sectorAddr),
    .wrValid     (wrValid),
    .wrByte      (wrByte),
    .wrReady     (wrReady),
    .sectorDone  (sectorDone)
  );

endmodule

`default_nettype wire

// ==== tb/fileLoggerTb.sv ====
// testbench for the uart-to-file logger with serial driver, block-device model and sector checks
`timescale 1ns/1ps
`default_nettype none

module fileLoggerTb import logPkg::*; ();

  logic clk;
  logic rstn;
  logic rx;
  logic wrReady;
  logic sectorDone;
  logic sectorStart;
  sectorAddrT sectorAddr;
  logic wrValid;
  byteT wrByte;

  // stimulus records from the data file
  int recCount[$];
  int recFirst[$];
  int recIncr[$];
  int recGap[$];
  int recBad[$];

  // good-frame bytes in send order
  byteT expStream[$];
  int goodQueued;
  int seed = 95;
  longint limitNs;

  // block-device model state
  int startCount;
  int xferCount;
  int doneDelay;

  fileLogger dut_i (
    .clk         (clk),
    .rstn        (rstn),
    .rx          (rx),
    .sectorStart (sectorStart),
    .sectorAddr  (sectorAddr),
    .wrValid     (wrValid),
    .wrByte      (wrByte),
    .wrReady     (wrReady),
    .sectorDone  (sectorDone)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  task automatic abortRun(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "run aborted");
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error: %s actual 0x%h expected 0x%h", name, actual, expected);
      $display("test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // directory sector as laid out for a fat 8.3 entry in slot 0
  function automatic byteT dirByteRef(input int idx, input logic [31:0] len);
    byteT entry [32];
    for (int i = 0; i < 32; i++) begin
      entry[i] = 8'h00;
    end
    for (int i = 0; i < 11; i++) begin
      entry[i] = fileName83[8 * (10 - i) +: 8];
    end
    entry[11] = archiveAttr;
    {entry[21], entry[20]} = firstCluster[31:16];
    {entry[27], entry[26]} = firstCluster[15:0];
    {entry[31], entry[30], entry[29], entry[28]} = len;
    return (idx < 32) ? entry[idx] : 8'h00;
  endfunction

  // records plus the watchdog window they need
  task automatic loadRecords();
    int fd;
    int cnt;
    int first;
    int incr;
    int gap;
    int bad;
    string line;
    fd = $fopen("tb/testdata.txt", "r");
    if (fd == 0) begin
      abortRun("could not open the stimulus file tb/testdata.txt");
    end
    while ($fgets(line, fd) != 0) begin
      // comment and blank lines do not scan
      if ($sscanf(line, "%d %h %h %d %d", cnt, first, incr, gap, bad) == 5) begin
        recCount.push_back(cnt);
        recFirst.push_back(first);
        recIncr.push_back(incr);
        recGap.push_back(gap);
        recBad.push_back(bad);
      end
    end
    $fclose(fd);
    limitNs = longint'(100000);
    foreach (recCount[i]) begin
      limitNs = limitNs + longint'(recCount[i]) * longint'(10 + recGap[i])
                * longint'(clksPerBit * 10 * 2);
    end
  endtask

  // ------------------------------------------------------------------
  // uart driver for 8N1 frames sent lsb first
  // ------------------------------------------------------------------
  task automatic sendByte(input byteT value, input int gapBits, input bit badStop);
    rx = 1'b0;
    repeat (clksPerBit) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      rx = value[i];
      repeat (clksPerBit) @(negedge clk);
    end
    // stop bit pulled low for a framing error
    rx = !badStop;
    repeat (clksPerBit) @(negedge clk);
    rx = 1'b1;
    repeat (gapBits * clksPerBit) @(negedge clk);
  endtask

  task automatic sendRecord(input int idx);
    byteT value;
    value = byteT'(recFirst[idx]);
    for (int k = 0; k < recCount[idx]; k++) begin
      if (recBad[idx] == 0) begin
        expStream.push_back(value);
        goodQueued++;
      end
      sendByte(value, recGap[idx], recBad[idx] != 0);
      value = value + byteT'(recIncr[idx]);
    end
  endtask

  // ------------------------------------------------------------------
  // block-device model driven on the falling edge
  // ------------------------------------------------------------------
  always @(negedge clk) begin
    if (rstn) begin
      sectorDone = 1'b0;
      if (doneDelay > 0) begin
        doneDelay = doneDelay - 1;
        if (doneDelay == 0) begin
          sectorDone = 1'b1;
        end
      end
      // stall roughly one cycle in three
      wrReady = ({$random(seed)} % 32'd3) != 32'd0;
      // nothing may start before a full sector was sent
      if (goodQueued < sectorBytes) begin
        checkValue("sectorStart", 32'(sectorStart), 32'd0);
        checkValue("wrValid", 32'(wrValid), 32'd0);
      end
      if (sectorStart) begin
        if (startCount > 0) begin
          checkValue("transfers", 32'(xferCount), 32'(sectorBytes));
          // previous sector must have been acknowledged first
          checkValue("pending sectorDone", 32'(doneDelay), 32'd0);
        end
        // data sector k and then its directory sector
        if (startCount % 2 == 0) begin
          checkValue("sectorAddr", sectorAddr, dataStartSector + sectorAddrT'(startCount / 2));
        end else begin
          checkValue("sectorAddr", sectorAddr, dirSector);
        end
        startCount++;
        xferCount = 0;
      end
      if (wrValid && wrReady) begin
        if (startCount == 0) begin
          abortRun("byte transfer seen before any sector start");
        end
        if (xferCount >= sectorBytes) begin
          abortRun("more than one sector of transfers after a single sector start");
        end
        if (startCount % 2 == 1) begin
          if (expStream.size() == 0) begin
            abortRun("data sector ran past the bytes that were sent");
          end
          checkValue("wrByte", 32'(wrByte), 32'(expStream.pop_front()));
        end else begin
          // length covers every data sector so far
          checkValue("wrByte", 32'(wrByte),
                     32'(dirByteRef(xferCount, 32'(sectorBytes * (startCount / 2)))));
        end
        xferCount++;
        if (xferCount == sectorBytes) begin
          doneDelay = 1 + int'({$random(seed)} % 32'd40);
        end
      end
    end
  end

  // watchdog window from the stimulus length
  initial begin
    wait (limitNs > 0);
    #(limitNs);
    $display("run hung, no completion within %0d ns", limitNs);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    rx = 1'b1;
    rstn = 1'b0;
    wrReady = 1'b0;
    sectorDone = 1'b0;
    goodQueued = 0;
    startCount = 0;
    xferCount = 0;
    doneDelay = 0;
    limitNs = 0;
    loadRecords();
    repeat (16) @(negedge clk);
    rstn = 1'b1;
    foreach (recCount[i]) begin
      sendRecord(i);
    end
    // leftover bytes must not start another sector
    repeat (20 * 10 * clksPerBit) @(negedge clk);
    checkValue("sectorStart count", 32'(startCount), 32'd4);
    checkValue("transfers", 32'(xferCount), 32'(sectorBytes));
    checkValue("pending sectorDone", 32'(doneDelay), 32'd0);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/testdata.txt ====
# count(dec) first(hex) increment(hex) gapBits(dec) frameError(0/1)
# one byte per frame, value = first + n * increment, gap of idle bits after each byte
120 00 01 0 0
64 80 03 1 0
1 3c 00 2 1
50 ff ff 0 0
40 10 07 2 0
80 55 00 0 0
33 aa 11 1 0
60 01 02 0 0
45 c3 05 3 0
70 20 01 0 0
25 f0 fd 1 0
90 7f 0b 0 0
55 00 00 2 0
48 e1 13 0 0
66 33 01 1 0
72 9c 07 0 0
38 40 0f 0 0
57 d2 01 1 0
44 08 29 0 0
43 6e 03 2 0

// ==== project.f ====
common/logPkg.sv
design/uart/uartRx.sv
design/byteFifo.sv
design/logWriter/dirEntryBuilder.sv
design/logWriter/logWriter.sv
design/fileLogger.sv
tb/fileLoggerTb.sv

// ==== Makefile ====
# Verilator flow for the UART-to-file logger testbench
TOP := fileLoggerTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -o $(TOP)

# a $fatal in the testbench gives a nonzero exit status
run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir
